// File: Bender.yml
package:
  name: l15_frontend

dependencies: {}

sources:
  - hdl/fetch_pkg.sv
  - hdl/fetch_stage.sv
  - hdl/fetch_queue.sv
  - hdl/decode_stage.sv
  - hdl/frontend_top.sv
  - target: test
    files:
      - verif/l15_responder.sv
      - verif/frontend_tb.sv

// File: hdl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  wire                clk,
	input  wire                nrst,
	input  wire                stall,
	input  wire                q_req,
	input  wire         [31:0] q_pc,
	input  wire         [31:0] q_instr,
	output logic               q_ack,
	output logic               redirect,
	output logic        [31:0] redirect_pc,
	output logic               dec_valid,
	output logic        [31:0] dec_pc,
	output logic        [31:0] dec_instr,
	output fetch_pkg::opcode_t dec_op
);

	logic               held;	// captured item not yet handed to the back-end
	logic               capture;
	fetch_pkg::opcode_t op;
	logic        [31:0] j_imm;

	function automatic fetch_pkg::opcode_t classify(input logic [6:0] major);
		fetch_pkg::opcode_t res;
		case (major)
			7'b0110011: res = fetch_pkg::op_alu;
			7'b0010011: res = fetch_pkg::op_alu_imm;
			7'b0110111: res = fetch_pkg::op_lui;
			7'b0010111: res = fetch_pkg::op_auipc;
			7'b0000011: res = fetch_pkg::op_load;
			7'b0100011: res = fetch_pkg::op_store;
			7'b1100011: res = fetch_pkg::op_branch;	// taken as not-taken
			7'b1101111: res = fetch_pkg::op_jal;
			7'b1100111: res = fetch_pkg::op_jalr;
			7'b1110011: res = fetch_pkg::op_system;
			default:    res = fetch_pkg::op_illegal;
		endcase
		return res;
	endfunction

	// phase 2, take the item only when the output register is free
	assign capture = q_req && !q_ack && !held;

	assign op = classify(q_instr[6:0]);

	// J-type immediate, bit 0 always zero
	assign j_imm = {{11{q_instr[31]}}, q_instr[31], q_instr[19:12], q_instr[20],
		q_instr[30:21], 1'b0};

	assign redirect    = capture && (op == fetch_pkg::op_jal);
	assign redirect_pc = q_pc + j_imm;

	assign dec_valid = held && !stall;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			q_ack <= 1'b0;
			held  <= 1'b0;
		end
		else
		begin
			if (capture)
				q_ack <= 1'b1;
			else if (!q_req)
				q_ack <= 1'b0;	// phase 4
			if (capture)
				held <= 1'b1;
			else if (dec_valid)
				held <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			dec_pc    <= q_pc;
			dec_instr <= q_instr;
			dec_op    <= op;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// L1.5 request fields
	localparam logic [4:0] rqtype_load   = 5'b00000;
	localparam logic [2:0] req_size_word = 3'b010;	// 4 byte access

	// L1.5 return types
	localparam logic [3:0] ret_load   = 4'b0000;	// carries instruction data
	localparam logic [3:0] ret_ifill  = 4'b0001;	// carries instruction data
	localparam logic [3:0] ret_inv    = 4'b0011;
	localparam logic [3:0] ret_st_ack = 4'b0100;
	localparam logic [3:0] ret_int    = 4'b0111;	// wake-up message

	localparam logic [31:0] reset_pc = 32'h4000_0000;

	// queue sizing, depth must stay a power of two
	localparam int queue_depth = 4;
	localparam int queue_ptr_w = 2;

	typedef enum logic [1:0] {
		st_sleep,	// waiting for the wake-up message
		st_req,
		st_resp
	} fetch_state_t;

	// classes from the RISC-V major opcode
	typedef enum logic [3:0] {
		op_alu,
		op_alu_imm,
		op_lui,
		op_auipc,
		op_load,
		op_store,
		op_branch,
		op_jal,
		op_jalr,
		op_system,
		op_illegal
	} opcode_t;

endpackage

`default_nettype wire

// File: hdl/fetch_queue.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_queue (
	input  wire         clk,
	input  wire         nrst,
	input  wire         push,
	input  wire  [31:0] push_pc,
	input  wire  [31:0] push_instr,
	input  wire         q_ack,
	input  wire         flush,
	output logic        queue_space,
	output logic        q_req,
	output logic [31:0] q_pc,
	output logic [31:0] q_instr
);

	logic [31:0] pc_mem [fetch_pkg::queue_depth];
	logic [31:0] instr_mem [fetch_pkg::queue_depth];
	logic [fetch_pkg::queue_ptr_w-1:0] wr_ptr;
	logic [fetch_pkg::queue_ptr_w-1:0] rd_ptr;
	logic [fetch_pkg::queue_ptr_w:0]   count;
	logic pop;

	assign pop = q_req && q_ack;	// phase 3, entry leaves on this edge

	// one request outstanding at most, so a single free slot is enough
	assign queue_space = (count < (fetch_pkg::queue_ptr_w + 1)'(fetch_pkg::queue_depth));

	// head entry, steady while q_req is up since rd_ptr moves only on pop
	assign q_pc    = pc_mem[rd_ptr];
	assign q_instr = instr_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push && !flush)
		begin
			pc_mem[wr_ptr]    <= push_pc;
			instr_mem[wr_ptr] <= push_instr;
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			q_req  <= 1'b0;
		end
		else if (flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			q_req  <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;

			if (pop)
				q_req <= 1'b0;
			else if (!q_req && !q_ack && (count != '0))
				q_req <= 1'b1;	// wait for ack low before next item
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
	input  wire         clk,
	input  wire         nrst,
	input  wire         queue_space,
	input  wire         redirect,
	input  wire  [31:0] redirect_pc,
	input  wire         l15_rq_header_ack,
	input  wire         l15_rs_val,
	input  wire  [3:0]  l15_rs_type,
	input  wire  [63:0] l15_rs_data_0,
	input  wire  [63:0] l15_rs_data_1,
	output logic        l15_rq_val,
	output logic [4:0]  l15_rq_type,
	output logic [2:0]  l15_rq_size,
	output logic [31:0] l15_rq_addr,
	output logic        l15_rs_ack,
	output logic        push,
	output logic [31:0] push_pc,
	output logic [31:0] push_instr
);

	fetch_pkg::fetch_state_t state;
	logic [31:0] pc;	// redirect target while a dead request is in flight
	logic [31:0] rq_addr;	// address being requested or awaited
	logic        discard;	// outstanding response is on a flushed path
	logic        woken;
	logic        is_data;
	logic        data_resp;
	logic [31:0] next_pc;
	logic [31:0] word;

	// leaving st_sleep is the wake-up latch
	assign woken = (state != fetch_pkg::st_sleep);

	assign is_data = (l15_rs_type == fetch_pkg::ret_load) ||
		(l15_rs_type == fetch_pkg::ret_ifill);
	assign data_resp = l15_rs_val && is_data && (state == fetch_pkg::st_resp);

	// queue_space cannot fall while val is up, so the request stays stable
	assign l15_rq_val  = (state == fetch_pkg::st_req) && queue_space;
	assign l15_rq_type = fetch_pkg::rqtype_load;
	assign l15_rq_size = fetch_pkg::req_size_word;
	assign l15_rq_addr = rq_addr;

	// before wake-up only the interrupt return is taken
	assign l15_rs_ack = l15_rs_val && (woken || (l15_rs_type == fetch_pkg::ret_int));

	// word 0 sits in the high half of data_0
	always_comb
	begin
		case (rq_addr[3:2])
			2'b00: word = l15_rs_data_0[63:32];
			2'b01: word = l15_rs_data_0[31:0];
			2'b10: word = l15_rs_data_1[63:32];
			default: word = l15_rs_data_1[31:0];
		endcase
	end

	assign next_pc = redirect ? redirect_pc : (discard ? pc : rq_addr + 32'd4);

	// a redirect in the same cycle flushes the queue, so drop the word too
	assign push       = data_resp && !discard && !redirect;
	assign push_pc    = rq_addr;
	assign push_instr = word;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state   <= fetch_pkg::st_sleep;
			pc      <= fetch_pkg::reset_pc;
			rq_addr <= fetch_pkg::reset_pc;
			discard <= 1'b0;
		end
		else
		begin
			case (state)
				fetch_pkg::st_sleep:
				begin
					if (l15_rs_val && (l15_rs_type == fetch_pkg::ret_int))
						state <= fetch_pkg::st_req;
				end
				fetch_pkg::st_req:
				begin
					if (l15_rq_val && l15_rq_header_ack)
						state <= fetch_pkg::st_resp;
					if (redirect)
					begin
						pc <= redirect_pc;
						if (l15_rq_val)
							discard <= 1'b1;	// address already on the port
						else
							rq_addr <= redirect_pc;
					end
				end
				fetch_pkg::st_resp:
				begin
					if (data_resp)
					begin
						state   <= fetch_pkg::st_req;
						discard <= 1'b0;
						pc      <= next_pc;
						rq_addr <= next_pc;
					end
					else if (redirect)
					begin
						pc      <= redirect_pc;
						discard <= 1'b1;
					end
				end
				default: state <= fetch_pkg::st_sleep;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/frontend_top.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_top (
	input  wire                clk,
	input  wire                nrst,
	input  wire                stall,
	// L1.5 request
	output logic               l15_rq_val,
	output logic        [4:0]  l15_rq_type,
	output logic        [2:0]  l15_rq_size,
	output logic        [31:0] l15_rq_addr,
	input  wire                l15_rq_header_ack,
	// L1.5 response
	input  wire                l15_rs_val,
	input  wire         [3:0]  l15_rs_type,
	input  wire         [63:0] l15_rs_data_0,
	input  wire         [63:0] l15_rs_data_1,
	output logic               l15_rs_ack,
	// back-end
	output logic               dec_valid,
	output logic        [31:0] dec_pc,
	output logic        [31:0] dec_instr,
	output fetch_pkg::opcode_t dec_op
);

	logic        queue_space;
	logic        push;
	logic [31:0] push_pc;
	logic [31:0] push_instr;
	logic        q_req;
	logic        q_ack;
	logic [31:0] q_pc;
	logic [31:0] q_instr;
	logic        redirect;	// also flushes the queue
	logic [31:0] redirect_pc;

	fetch_stage u_fetch (
		.clk(clk), .nrst(nrst), .queue_space(queue_space),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.l15_rq_header_ack(l15_rq_header_ack), .l15_rs_val(l15_rs_val),
		.l15_rs_type(l15_rs_type), .l15_rs_data_0(l15_rs_data_0),
		.l15_rs_data_1(l15_rs_data_1), .l15_rq_val(l15_rq_val),
		.l15_rq_type(l15_rq_type), .l15_rq_size(l15_rq_size),
		.l15_rq_addr(l15_rq_addr), .l15_rs_ack(l15_rs_ack),
		.push(push), .push_pc(push_pc), .push_instr(push_instr)
	);

	fetch_queue u_queue (
		.clk(clk), .nrst(nrst), .push(push), .push_pc(push_pc),
		.push_instr(push_instr), .q_ack(q_ack), .flush(redirect),
		.queue_space(queue_space), .q_req(q_req), .q_pc(q_pc), .q_instr(q_instr)
	);

	decode_stage u_decode (
		.clk(clk), .nrst(nrst), .stall(stall), .q_req(q_req), .q_pc(q_pc),
		.q_instr(q_instr), .q_ack(q_ack), .redirect(redirect),
		.redirect_pc(redirect_pc), .dec_valid(dec_valid), .dec_pc(dec_pc),
		.dec_instr(dec_instr), .dec_op(dec_op)
	);

endmodule

`default_nettype wire

// File: project.f
hdl/fetch_pkg.sv
hdl/fetch_stage.sv
hdl/fetch_queue.sv
hdl/decode_stage.sv
hdl/frontend_top.sv
verif/l15_responder.sv
verif/frontend_tb.sv

// File: verif/frontend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_tb;

	localparam int n_target    = 300;
	localparam int cycle_limit = n_target * 40 + 100;

	logic               clk;
	logic               nrst;
	logic               stall;
	logic               l15_rq_val;
	logic        [4:0]  l15_rq_type;
	logic        [2:0]  l15_rq_size;
	logic        [31:0] l15_rq_addr;
	logic               l15_rq_header_ack;
	logic               l15_rs_val;
	logic        [3:0]  l15_rs_type;
	logic        [63:0] l15_rs_data_0;
	logic        [63:0] l15_rs_data_1;
	logic               l15_rs_ack;
	logic               dec_valid;
	logic        [31:0] dec_pc;
	logic        [31:0] dec_instr;
	fetch_pkg::opcode_t dec_op;

	integer      seed;
	int          stall_run;
	int          cycles;
	int          n_done;
	int          outstanding;
	logic        woke;
	logic        first_req;
	logic        failed;
	logic [31:0] exp_pc;

	frontend_top u_dut (.*);

	l15_responder u_l15 (.*);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			failed = 1'b1;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	// program order, JAL slots jump by their known offset
	function automatic logic [31:0] next_expected(input logic [31:0] pc);
		logic [31:0] off;
		off = u_l15.jal_offset(pc);
		return (off != 32'd0) ? pc + off : pc + 32'd4;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		seed        = 32'h0ee3_d9c2;
		nrst        = 1'b0;
		stall       = 1'b0;
		stall_run   = 0;
		cycles      = 0;
		n_done      = 0;
		outstanding = 0;
		woke        = 1'b0;
		first_req   = 1'b1;
		failed      = 1'b0;
		exp_pc      = fetch_pkg::reset_pc;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
	end

	// short random stalls with a long run now and then
	always @(posedge clk)
	begin
		if (stall_run > 0)
		begin
			stall     <= 1'b1;
			stall_run <= stall_run - 1;
		end
		else if (($random(seed) & 63) == 0)
			stall_run <= 16 + ($unsigned($random(seed)) % 24);
		else
			stall <= (($random(seed) & 3) == 0);
	end

	// L1.5 port rules
	always @(posedge clk)
	begin
		if (nrst)
		begin
			if (!woke)
				check_value("no fetch before wake-up", 32'd0, {31'd0, l15_rq_val});
			if (outstanding != 0)
				check_value("one request outstanding", 32'd0, {31'd0, l15_rq_val});
			if (l15_rq_val)
			begin
				check_value("request type", fetch_pkg::rqtype_load, l15_rq_type);
				check_value("request size", fetch_pkg::req_size_word, l15_rq_size);
			end
			if (l15_rs_val && woke)
				check_value("response acked", 32'd1, {31'd0, l15_rs_ack});
			if (l15_rs_val && l15_rs_ack && (l15_rs_type == fetch_pkg::ret_int))
				woke = 1'b1;
			if (l15_rq_val && l15_rq_header_ack)
			begin
				if (first_req)
					check_value("first request address", fetch_pkg::reset_pc, l15_rq_addr);
				first_req = 1'b0;
				outstanding = outstanding + 1;
			end
			if (l15_rs_val && l15_rs_ack && ((l15_rs_type == fetch_pkg::ret_load) ||
				(l15_rs_type == fetch_pkg::ret_ifill)))
				outstanding = outstanding - 1;
		end
	end

	// decode output against the reference walk
	always @(posedge clk)
	begin
		if (dec_valid)
		begin
			check_value("dec_valid while stalled", 32'd0, {31'd0, stall});
			check_value("decode pc", exp_pc, dec_pc);
			check_value("decode instr", u_l15.mem_word(exp_pc), dec_instr);
			check_value("decode opcode", u_l15.word_kind(exp_pc), dec_op);
			exp_pc = next_expected(exp_pc);
			n_done = n_done + 1;
			if (n_done == n_target)
			begin
				if (!failed)
				begin
					$display("Regression passed");
					$finish;
				end
				else
				begin
					$display("Regression failed");
					$fatal(1);
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timed out before all instructions were decoded (%0d of %0d)",
				n_done, n_target);
			$display("Regression failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: verif/l15_responder.sv
`timescale 1ns/1ns
`default_nettype none

module l15_responder (
	input  wire         clk,
	input  wire         nrst,
	input  wire         l15_rq_val,
	input  wire  [31:0] l15_rq_addr,
	output logic        l15_rq_header_ack,
	output logic        l15_rs_val,
	output logic [3:0]  l15_rs_type,
	output logic [63:0] l15_rs_data_0,
	output logic [63:0] l15_rs_data_1,
	input  wire         l15_rs_ack
);

	integer      seed;
	int          wait_n;
	logic [31:0] addr;
	logic [3:0]  stray;

	// jump distance in bytes at the JAL slots, zero elsewhere
	function automatic logic [31:0] jal_offset(input logic [31:0] pc);
		logic [31:0] idx;
		logic [31:0] off;
		idx = (pc - fetch_pkg::reset_pc) >> 2;
		if (idx[5:0] == 6'd13)
			off = 32'd20;	// lands on word position 2
		else if (idx[6:0] == 7'd98)
			off = 32'd36;	// lands on word position 3
		else
			off = 32'd0;
		return off;
	endfunction

	function automatic fetch_pkg::opcode_t word_kind(input logic [31:0] pc);
		logic [31:0] idx;
		fetch_pkg::opcode_t kind;
		idx = (pc - fetch_pkg::reset_pc) >> 2;
		if (jal_offset(pc) != 32'd0)
			kind = fetch_pkg::op_jal;
		else if (idx == 32'd7)
			kind = fetch_pkg::op_branch;	// never taken
		else if (idx[4:0] == 5'd22)
			kind = fetch_pkg::op_illegal;
		else if (idx[0])
			kind = fetch_pkg::op_load;
		else
			kind = fetch_pkg::op_alu;
		return kind;
	endfunction

	// memory image, upper bits scrambled from the whole address
	function automatic logic [31:0] mem_word(input logic [31:0] pc);
		logic [31:0] hash;
		logic [31:0] off;
		logic [31:0] w;
		hash = pc ^ {pc[15:0], pc[31:16]} ^ 32'h5a3c_96e1;
		off = jal_offset(pc);
		case (word_kind(pc))
			fetch_pkg::op_jal:
				w = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
			fetch_pkg::op_branch:  w = {hash[31:7], 7'b1100011};
			fetch_pkg::op_illegal: w = {hash[31:7], 7'b1111111};
			fetch_pkg::op_load:    w = {hash[31:7], 7'b0000011};
			default:               w = {hash[31:7], 7'b0110011};
		endcase
		return w;
	endfunction

	// one response, held until the fetch stage acks it
	task automatic send_resp(input logic [3:0] kind, input logic [31:0] pc);
		logic [31:0] base;
		base = {pc[31:4], 4'b0000};
		l15_rs_type   <= kind;
		l15_rs_data_0 <= {mem_word(base), mem_word(base + 32'd4)};
		l15_rs_data_1 <= {mem_word(base + 32'd8), mem_word(base + 32'd12)};
		l15_rs_val    <= 1'b1;
		do
			@(posedge clk);
		while (!l15_rs_ack);
		l15_rs_val <= 1'b0;
	endtask

	initial
	begin
		seed              = 32'h0ee3_d9c2;
		l15_rq_header_ack = 1'b0;
		l15_rs_val        = 1'b0;
		l15_rs_type       = 4'h0;
		l15_rs_data_0     = '0;
		l15_rs_data_1     = '0;
		@(posedge nrst);
		repeat (10) @(posedge clk);
		send_resp(fetch_pkg::ret_int, 32'h0);	// wake-up
		forever
		begin
			@(posedge clk);
			if (l15_rq_val)
			begin
				addr   = l15_rq_addr;
				wait_n = $unsigned($random(seed)) % 3;
				repeat (wait_n) @(posedge clk);
				l15_rq_header_ack <= 1'b1;
				@(posedge clk);	// header handshake
				l15_rq_header_ack <= 1'b0;
				wait_n = $unsigned($random(seed)) % 6;
				repeat (wait_n) @(posedge clk);
				if (($random(seed) & 3) == 0)
				begin
					stray = (($random(seed) & 1) != 0) ? fetch_pkg::ret_inv : fetch_pkg::ret_st_ack;
					send_resp(stray, addr);
				end
				if (($random(seed) & 1) != 0)
					send_resp(fetch_pkg::ret_ifill, addr);
				else
					send_resp(fetch_pkg::ret_load, addr);
			end
		end
	end

endmodule

`default_nettype wire
